// ==== project.f ====
+incdir+include
src/trig_pkg.sv
src/trig_csr_bank.sv
src/trig_unit.sv
src/trig_chain_resolve.sv
src/trig_top.sv
dv/trig_checker.sv
dv/trig_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the trigger testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module trig_tb -o trig_sim

./obj_dir/trig_sim > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi

echo "simulation passed"

// ==== dv/trig_tb.sv ====
// Trigger module testbench
`timescale 1ns/1ns
`default_nettype none

`include "trig_cfg.svh"

module trig_tb
    import trig_pkg::*;
();

    localparam int RESET_TIMEOUT = 40;
    localparam int DRAIN_TIMEOUT = 10;
    localparam logic [31:0] PC_A = 32'h8000_0100;
    localparam logic [31:0] WIN_LO = 32'h0000_4000;
    localparam logic [31:0] WIN_HI = 32'h0000_8000;

    typedef struct packed {
        csr_req_t     req;
        logic         halt;
        priv_e        priv;
        trig_addr_t   pc;
        ls_req_t      ls;
        logic [31:0]  exp_rdata;
        logic         chk_rdata;
        trig_result_t exp_exec;
        trig_result_t exp_ls;
    } row_t;

    logic         core_clk;
    logic         core_reset_n;
    csr_req_t     csr_req;
    logic         halt_mode;
    priv_e        priv;
    trig_addr_t   exec_pc;
    ls_req_t      ls_req;
    logic [31:0]  csr_rdata;
    trig_result_t exec_result;
    trig_result_t ls_result;

    logic         chk_active;
    logic [31:0]  row_idx;
    logic [31:0]  exp_rdata;
    logic         chk_rdata;
    trig_result_t exp_exec;
    trig_result_t exp_ls;
    int           error_count;
    int           check_count;

    row_t   rows [$];
    integer seed;
    int     timeouts;

    trig_top dut0 (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .csr_req      (csr_req),
        .csr_rdata    (csr_rdata),
        .halt_mode    (halt_mode),
        .priv         (priv),
        .exec_pc      (exec_pc),
        .ls_req       (ls_req),
        .exec_result  (exec_result),
        .ls_result    (ls_result)
    );

    trig_checker u_checker (
        .core_clk    (core_clk),
        .active      (chk_active),
        .row_idx     (row_idx),
        .exp_rdata   (exp_rdata),
        .chk_rdata   (chk_rdata),
        .exp_exec    (exp_exec),
        .exp_ls      (exp_ls),
        .csr_rdata   (csr_rdata),
        .exec_result (exec_result),
        .ls_result   (ls_result),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial core_clk = 1'b0;
    always #50 core_clk = ~core_clk;

    initial begin
        core_reset_n = 1'b0;
        repeat (16) @(posedge core_clk);
        #5;
        core_reset_n = 1'b1;
    end

    // tdata1 word built field by field from the type down.
    function automatic logic [31:0] ctrl_word(input trig_type_e t, input logic dmode,
        input trig_action_e act, input logic chain, input trig_match_e mt, input logic m,
        input logic u, input logic ex, input logic st, input logic ld);
        return {t, dmode, 11'b0, act, chain, mt, m, u, ex, st, ld};
    endfunction

    task automatic add_row(input logic we, input csr_addr_e addr, input logic [31:0] wdata,
        input logic halt, input priv_e p, input trig_addr_t pc, input ls_req_t ls,
        input logic [31:0] rd, input logic chk, input trig_result_t ex,
        input trig_result_t lr);
        row_t r;
        r.req.we    = we;
        r.req.addr  = addr;
        r.req.wdata = wdata;
        r.halt      = halt;
        r.priv      = p;
        r.pc        = pc;
        r.ls        = ls;
        r.exp_rdata = rd;
        r.chk_rdata = chk;
        r.exp_exec  = ex;
        r.exp_ls    = lr;
        rows.push_back(r);
    endtask

    // user mode with u never set keeps register accesses free of hits.
    task automatic csr_write(input csr_addr_e addr, input logic [31:0] data, input logic halt);
        add_row(1'b1, addr, data, halt, priv_user, '0, '0, '0, 1'b0, '0, '0);
    endtask

    task automatic csr_read(input csr_addr_e addr, input logic [31:0] exp, input logic halt);
        add_row(1'b0, addr, '0, halt, priv_user, '0, '0, exp, 1'b1, '0, '0);
    endtask

    task automatic exec_probe(input priv_e p, input trig_addr_t pc, input logic halt,
        input logic brk, input logic hlt);
        trig_result_t r;
        r.brk  = brk;
        r.halt = hlt;
        add_row(1'b0, csr_tselect, '0, halt, p, pc, '0, '0, 1'b0, r, '0);
    endtask

    task automatic ls_probe(input priv_e p, input logic ld, input logic st,
        input trig_addr_t addr, input logic halt, input logic brk, input logic hlt);
        ls_req_t      l;
        trig_result_t r;
        l.load  = ld;
        l.store = st;
        l.addr  = addr;
        r.brk   = brk;
        r.halt  = hlt;
        add_row(1'b0, csr_tselect, '0, halt, p, '0, l, '0, 1'b0, '0, r);
    endtask

    task automatic build_table();
        logic [31:0] lock_word;
        trig_addr_t  pc;
        logic        in_win;
        logic        halt;
        // reset values.
        csr_read(csr_tselect, 32'h0, 1'b0);
        for (int i = 0; i < `TRIG_NUM; i++) begin
            csr_write(csr_tselect, 32'(i), 1'b0);
            csr_read(csr_tselect, 32'(i), 1'b0);
            csr_read(csr_tdata1, 32'h0, 1'b0);
            csr_read(csr_tdata2, 32'h0, 1'b0);
        end
        exec_probe(priv_machine, '0, 1'b0, 1'b0, 1'b0);
        ls_probe(priv_machine, 1'b1, 1'b1, '0, 1'b0, 1'b0, 1'b0);
        // readback, dmode cleared outside halt, unknown type falls back to none.
        for (int i = 0; i < `TRIG_NUM - 1; i++) begin
            csr_write(csr_tselect, 32'(i), 1'b0);
            csr_write(csr_tdata1, ctrl_word(type_addr_match, 1'b1, action_halt, 1'b0,
                match_lt, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1), 1'b0);
            csr_write(csr_tdata2, 32'h1234_5600 | 32'(i), 1'b0);
            csr_read(csr_tdata1, ctrl_word(type_addr_match, 1'b0, action_halt, 1'b0,
                match_lt, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1), 1'b0);
            csr_read(csr_tdata2, 32'h1234_5600 | 32'(i), 1'b0);
            csr_write(csr_tdata1, 32'hf000_0014, 1'b0);
            csr_read(csr_tdata1, 32'h0000_0014, 1'b0);
        end
        // debugger claims the last trigger in halt mode.
        lock_word = ctrl_word(type_none, 1'b1, action_brk, 1'b0, match_eq, 1'b0, 1'b0,
            1'b0, 1'b0, 1'b0);
        csr_write(csr_tselect, 32'(`TRIG_NUM - 1), 1'b1);
        csr_write(csr_tdata1, lock_word, 1'b1);
        csr_write(csr_tdata2, 32'hdead_beef, 1'b1);
        csr_read(csr_tdata1, lock_word, 1'b1);
        csr_read(csr_tdata2, 32'hdead_beef, 1'b1);
        csr_write(csr_tdata1, ctrl_word(type_addr_match, 1'b0, action_brk, 1'b0, match_eq,
            1'b1, 1'b0, 1'b1, 1'b0, 1'b0), 1'b0);
        csr_write(csr_tdata2, 32'h0000_0001, 1'b0);
        csr_read(csr_tdata1, lock_word, 1'b0);
        csr_read(csr_tdata2, 32'hdead_beef, 1'b0);
        // execute eq on trigger 0.
        csr_write(csr_tselect, 32'h0, 1'b0);
        csr_write(csr_tdata2, PC_A, 1'b0);
        csr_write(csr_tdata1, ctrl_word(type_addr_match, 1'b0, action_brk, 1'b0, match_eq,
            1'b1, 1'b0, 1'b1, 1'b0, 1'b0), 1'b0);
        exec_probe(priv_machine, PC_A, 1'b0, 1'b1, 1'b0);
        exec_probe(priv_machine, PC_A + 32'h4, 1'b0, 1'b0, 1'b0);
        exec_probe(priv_user, PC_A, 1'b0, 1'b0, 1'b0);
        exec_probe(priv_machine, PC_A, 1'b1, 1'b0, 1'b0);
        csr_write(csr_tdata1, ctrl_word(type_addr_match, 1'b0, action_halt, 1'b0, match_eq,
            1'b1, 1'b0, 1'b1, 1'b0, 1'b0), 1'b0);
        exec_probe(priv_machine, PC_A, 1'b0, 1'b0, 1'b1);
        exec_probe(priv_machine, PC_A, 1'b1, 1'b0, 1'b0);
        csr_write(csr_tdata1, 32'h0, 1'b0);
        // load/store compares on trigger 1.
        csr_write(csr_tselect, 32'h1, 1'b0);
        csr_write(csr_tdata2, 32'h2000_0000, 1'b0);
        csr_write(csr_tdata1, ctrl_word(type_addr_match, 1'b0, action_brk, 1'b0, match_ge,
            1'b1, 1'b0, 1'b0, 1'b0, 1'b1), 1'b0);
        ls_probe(priv_machine, 1'b0, 1'b1, 32'h2000_0010, 1'b0, 1'b0, 1'b0);
        ls_probe(priv_machine, 1'b1, 1'b0, 32'h2000_0010, 1'b0, 1'b1, 1'b0);
        ls_probe(priv_machine, 1'b1, 1'b0, 32'h1fff_fffc, 1'b0, 1'b0, 1'b0);
        ls_probe(priv_machine, 1'b1, 1'b0, 32'h2000_0010, 1'b1, 1'b0, 1'b0);
        csr_write(csr_tdata1, ctrl_word(type_addr_match, 1'b0, action_brk, 1'b0, match_lt,
            1'b1, 1'b0, 1'b0, 1'b0, 1'b1), 1'b0);
        ls_probe(priv_machine, 1'b1, 1'b0, 32'h1fff_fffc, 1'b0, 1'b1, 1'b0);
        ls_probe(priv_machine, 1'b1, 1'b0, 32'h2000_0000, 1'b0, 1'b0, 1'b0);
        csr_write(csr_tdata2, {16'hff00, 16'h1200}, 1'b0);
        csr_write(csr_tdata1, ctrl_word(type_addr_match, 1'b0, action_brk, 1'b0, match_mask,
            1'b1, 1'b0, 1'b0, 1'b1, 1'b1), 1'b0);
        ls_probe(priv_machine, 1'b0, 1'b1, 32'h0000_12ab, 1'b0, 1'b1, 1'b0);
        ls_probe(priv_machine, 1'b1, 1'b0, 32'h0000_13ab, 1'b0, 1'b0, 1'b0);
        ls_probe(priv_machine, 1'b1, 1'b0, 32'habcd_12ff, 1'b0, 1'b1, 1'b0);
        ls_probe(priv_machine, 1'b1, 1'b0, 32'habcd_12ff, 1'b1, 1'b0, 1'b0);
        csr_write(csr_tdata1, ctrl_word(type_addr_match, 1'b0, action_halt, 1'b0, match_mask,
            1'b1, 1'b0, 1'b0, 1'b0, 1'b1), 1'b0);
        ls_probe(priv_machine, 1'b1, 1'b0, 32'habcd_12ff, 1'b0, 1'b0, 1'b1);
        csr_write(csr_tdata1, 32'h0, 1'b0);
        // chained window WIN_LO <= pc < WIN_HI.
        csr_write(csr_tselect, 32'h0, 1'b0);
        csr_write(csr_tdata2, WIN_LO, 1'b0);
        csr_write(csr_tdata1, ctrl_word(type_addr_match, 1'b0, action_brk, 1'b1, match_ge,
            1'b1, 1'b0, 1'b1, 1'b0, 1'b1), 1'b0);
        csr_write(csr_tselect, 32'h1, 1'b0);
        csr_write(csr_tdata2, WIN_HI, 1'b0);
        csr_write(csr_tdata1, ctrl_word(type_addr_match, 1'b0, action_brk, 1'b0, match_lt,
            1'b1, 1'b0, 1'b1, 1'b0, 1'b1), 1'b0);
        for (int n = 0; n < 24; n++) begin
            pc = trig_addr_t'($random(seed)) & 32'h0000_fffc;
            in_win = (pc >= WIN_LO) && (pc < WIN_HI);
            halt = (n % 6 == 5);
            exec_probe(priv_machine, pc, halt, in_win && !halt, 1'b0);
        end
        ls_probe(priv_machine, 1'b1, 1'b0, 32'h0000_5000, 1'b0, 1'b1, 1'b0);
        ls_probe(priv_machine, 1'b1, 1'b0, 32'h0000_9000, 1'b0, 1'b0, 1'b0);
        csr_write(csr_tdata1, 32'h0, 1'b0);
        exec_probe(priv_machine, 32'h0000_5000, 1'b0, 1'b0, 1'b0);
        exec_probe(priv_machine, 32'h0000_9000, 1'b0, 1'b0, 1'b0);
        ls_probe(priv_machine, 1'b1, 1'b0, 32'h0000_5000, 1'b0, 1'b0, 1'b0);
        csr_write(csr_tselect, 32'h0, 1'b0);
        csr_write(csr_tdata1, ctrl_word(type_addr_match, 1'b0, action_brk, 1'b0, match_ge,
            1'b1, 1'b0, 1'b1, 1'b0, 1'b0), 1'b0);
        exec_probe(priv_machine, 32'h0000_5000, 1'b0, 1'b1, 1'b0);
        exec_probe(priv_machine, 32'h0000_9000, 1'b0, 1'b1, 1'b0);
        exec_probe(priv_machine, 32'h0000_1000, 1'b0, 1'b0, 1'b0);
        exec_probe(priv_machine, 32'h0000_9000, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic apply_row(input int idx);
        csr_req    = rows[idx].req;
        halt_mode  = rows[idx].halt;
        priv       = rows[idx].priv;
        exec_pc    = rows[idx].pc;
        ls_req     = rows[idx].ls;
        exp_rdata  = rows[idx].exp_rdata;
        chk_rdata  = rows[idx].chk_rdata;
        exp_exec   = rows[idx].exp_exec;
        exp_ls     = rows[idx].exp_ls;
        row_idx    = 32'(idx);
        chk_active = 1'b1;
    endtask

    initial begin
        int waited;
        seed       = 32'hee70_fe57;
        timeouts   = 0;
        csr_req    = '0;
        halt_mode  = 1'b0;
        priv       = priv_user;
        exec_pc    = '0;
        ls_req     = '0;
        chk_active = 1'b0;
        row_idx    = '0;
        exp_rdata  = '0;
        chk_rdata  = 1'b0;
        exp_exec   = '0;
        exp_ls     = '0;
        build_table();
        waited = 0;
        while (core_reset_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge core_clk);
            waited++;
        end
        if (core_reset_n !== 1'b1) begin
            $display("timeout: reset was never released");
            timeouts++;
        end else begin
            foreach (rows[i]) begin
                @(posedge core_clk);
                #5;
                apply_row(i);
            end
            @(posedge core_clk);
            #5;
            chk_active = 1'b0;
            csr_req    = '0;
            waited     = 0;
            while (check_count < rows.size() && waited < DRAIN_TIMEOUT) begin
                @(posedge core_clk);
                waited++;
            end
            if (check_count < rows.size()) begin
                $display("timeout: checker saw only %0d of %0d rows", check_count, rows.size());
                timeouts++;
            end
        end
        $display("checks: %0d, value errors: %0d, timeouts: %0d",
            check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/trig_checker.sv ====
// Trigger output checker
`timescale 1ns/1ns
`default_nettype none

module trig_checker
    import trig_pkg::*;
(
    input  wire logic         core_clk,
    input  wire logic         active,
    input  wire logic [31:0]  row_idx,
    input  wire logic [31:0]  exp_rdata,
    input  wire logic         chk_rdata,
    input  wire trig_result_t exp_exec,
    input  wire trig_result_t exp_ls,
    input  wire logic [31:0]  csr_rdata,
    input  wire trig_result_t exec_result,
    input  wire trig_result_t ls_result,
    output int                error_count,
    output int                check_count
);

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic check_result(input string name, input trig_result_t exp,
        input trig_result_t act);
        if (act !== exp) begin
            $display("** Error row %0d: %s expected %h, got %h", row_idx, name, exp, act);
            errors++;
        end
    endtask

    // inputs change 5 ns after the rising edge, so the falling edge sees them settled.
    always @(negedge core_clk) begin
        if (active) begin
            if (chk_rdata && csr_rdata !== exp_rdata) begin
                $display("** Error row %0d: csr_rdata expected %h, got %h",
                    row_idx, exp_rdata, csr_rdata);
                errors++;
            end
            check_result("exec_result", exp_exec, exec_result);
            check_result("ls_result", exp_ls, ls_result);
            checks++;
        end
    end

endmodule

`default_nettype wire

// ==== src/trig_top.sv ====
// Debug trigger module top
`timescale 1ns/1ns
`default_nettype none

`include "trig_cfg.svh"

module trig_top
    import trig_pkg::*;
(
    input  wire logic       core_clk,
    input  wire logic       core_reset_n,
    input  wire csr_req_t   csr_req,
    output logic [31:0]     csr_rdata,
    input  wire logic       halt_mode,
    input  wire priv_e      priv,
    input  wire trig_addr_t exec_pc,
    input  wire ls_req_t    ls_req,
    output trig_result_t    exec_result,
    output trig_result_t    ls_result
);

    trig_cfg_t            trig_cfg [`TRIG_NUM];
    logic [`TRIG_NUM-1:0] exec_hit;
    logic [`TRIG_NUM-1:0] ls_hit;

    trig_csr_bank u_csr_bank (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .csr_req      (csr_req),
        .halt_mode    (halt_mode),
        .csr_rdata    (csr_rdata),
        .trig_cfg     (trig_cfg)
    );

    for (genvar i = 0; i < `TRIG_NUM; i++) begin : g_trig
        trig_unit u_trig_unit (
            .cfg      (trig_cfg[i]),
            .priv     (priv),
            .exec_pc  (exec_pc),
            .ls_req   (ls_req),
            .exec_hit (exec_hit[i]),
            .ls_hit   (ls_hit[i])
        );
    end

    trig_chain_resolve u_chain_resolve (
        .trig_cfg    (trig_cfg),
        .exec_hit    (exec_hit),
        .ls_hit      (ls_hit),
        .halt_mode   (halt_mode),
        .exec_result (exec_result),
        .ls_result   (ls_result)
    );

endmodule

`default_nettype wire

// ==== src/trig_chain_resolve.sv ====
// Trigger chain resolver
`timescale 1ns/1ns
`default_nettype none

`include "trig_cfg.svh"

module trig_chain_resolve
    import trig_pkg::*;
(
    input  wire trig_cfg_t          trig_cfg [`TRIG_NUM],
    input  wire logic [`TRIG_NUM-1:0] exec_hit,
    input  wire logic [`TRIG_NUM-1:0] ls_hit,
    input  wire logic               halt_mode,
    output trig_result_t            exec_result,
    output trig_result_t            ls_result
);

    logic [`TRIG_NUM-1:0] chain;
    logic [`TRIG_NUM-1:0] act_brk;
    logic [`TRIG_NUM-1:0] act_halt;
    logic [`TRIG_NUM-1:0] exec_chain_hit;
    logic [`TRIG_NUM-1:0] ls_chain_hit;
    logic [`TRIG_NUM-1:0] exec_fire;
    logic [`TRIG_NUM-1:0] ls_fire;
    logic                 exec_link;
    logic                 ls_link;

    always_comb begin
        for (int i = 0; i < `TRIG_NUM; i++) begin
            chain[i]    = trig_cfg[i].ctrl.chain;
            act_brk[i]  = (trig_cfg[i].ctrl.action == action_brk);
            act_halt[i] = (trig_cfg[i].ctrl.action == action_halt);
        end
    end

    // link carries whether the next trigger may count its own hit.
    always_comb begin
        exec_link = 1'b1; // trigger 0 has no predecessor.
        ls_link   = 1'b1;
        for (int i = 0; i < `TRIG_NUM; i++) begin
            exec_chain_hit[i] = exec_hit[i] & exec_link;
            ls_chain_hit[i]   = ls_hit[i] & ls_link;
            exec_link         = ~chain[i] | exec_chain_hit[i];
            ls_link           = ~chain[i] | ls_chain_hit[i];
        end
    end

    // only the last trigger of a chain fires.
    assign exec_fire = exec_chain_hit & ~chain;
    assign ls_fire   = ls_chain_hit & ~chain;

    assign exec_result.brk  = ~halt_mode & |(exec_fire & act_brk);
    assign exec_result.halt = ~halt_mode & |(exec_fire & act_halt);
    assign ls_result.brk    = ~halt_mode & |(ls_fire & act_brk);
    assign ls_result.halt   = ~halt_mode & |(ls_fire & act_halt);

endmodule

`default_nettype wire

// ==== src/trig_unit.sv ====
// Single address-match trigger
`timescale 1ns/1ns
`default_nettype none

module trig_unit
    import trig_pkg::*;
(
    input  wire trig_cfg_t  cfg,
    input  wire priv_e      priv,
    input  wire trig_addr_t exec_pc,
    input  wire ls_req_t    ls_req,
    output logic            exec_hit,
    output logic            ls_hit
);

    logic priv_ok;
    logic armed;
    logic exec_match;
    logic ls_match;
    logic ls_kind_ok;

    function automatic logic addr_hit(
        input trig_addr_t  addr,
        input trig_match_e mode,
        input logic [31:0] tdata2
    );
        trig_addr_t cmp;
        cmp = trig_addr_t'(tdata2);
        case (mode)
            match_eq:   addr_hit = (addr == cmp);
            // upper half of tdata2 selects which low address bits count.
            match_mask: addr_hit = ((addr[15:0] & tdata2[31:16]) == tdata2[15:0]);
            match_ge:   addr_hit = (addr >= cmp);
            match_lt:   addr_hit = (addr < cmp);
            default:    addr_hit = 1'b0;
        endcase
    endfunction

    always_comb begin
        case (priv)
            priv_machine: priv_ok = cfg.ctrl.m;
            priv_user:    priv_ok = cfg.ctrl.u;
            default:      priv_ok = 1'b0;
        endcase
    end

    assign armed = (cfg.ctrl.ttype == type_addr_match) & priv_ok;

    assign exec_match = addr_hit(exec_pc, cfg.ctrl.match, cfg.tdata2);
    assign ls_match   = addr_hit(ls_req.addr, cfg.ctrl.match, cfg.tdata2);

    assign ls_kind_ok = (cfg.ctrl.load & ls_req.load) | (cfg.ctrl.store & ls_req.store);

    assign exec_hit = armed & cfg.ctrl.execute & exec_match;
    assign ls_hit   = armed & ls_kind_ok & ls_match; // access kind must be enabled.

endmodule

`default_nettype wire

// ==== src/trig_csr_bank.sv ====
// Trigger CSR bank
`timescale 1ns/1ns
`default_nettype none

`include "trig_cfg.svh"

module trig_csr_bank
    import trig_pkg::*;
(
    input  wire logic      core_clk,
    input  wire logic      core_reset_n,
    input  wire csr_req_t  csr_req,
    input  wire logic      halt_mode,
    output logic [31:0]    csr_rdata,
    output trig_cfg_t      trig_cfg [`TRIG_NUM]
);

    logic [`TRIG_SEL_W-1:0] tselect;
    trig_ctrl_t             ctrl_q [`TRIG_NUM];
    logic [31:0]            tdata2_q [`TRIG_NUM];

    trig_ctrl_t sel_ctrl;
    logic       wr_allowed;
    trig_ctrl_t raw_ctrl;
    trig_ctrl_t wr_ctrl;

    assign sel_ctrl = ctrl_q[tselect];

    // a trigger owned by the debugger is locked outside halt mode.
    assign wr_allowed = halt_mode | ~sel_ctrl.dmode;

    assign raw_ctrl = trig_ctrl_t'(csr_req.wdata);

    always_comb begin
        wr_ctrl = raw_ctrl;
        wr_ctrl.zero = '0;
        if (!halt_mode) begin
            wr_ctrl.dmode = 1'b0; // only the debugger may claim a trigger.
        end
        if (raw_ctrl.ttype != type_addr_match) begin
            wr_ctrl.ttype = type_none; // unsupported types fall back to none.
        end
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            tselect <= '0;
            for (int i = 0; i < `TRIG_NUM; i++) begin
                ctrl_q[i]   <= '0;
                tdata2_q[i] <= '0;
            end
        end else if (csr_req.we) begin
            case (csr_req.addr)
                csr_tselect: begin
                    tselect <= csr_req.wdata[`TRIG_SEL_W-1:0];
                end
                csr_tdata1: begin
                    if (wr_allowed) begin
                        ctrl_q[tselect] <= wr_ctrl;
                    end
                end
                csr_tdata2: begin
                    if (wr_allowed) begin
                        tdata2_q[tselect] <= csr_req.wdata;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // combinational readback of the selected trigger.
    always_comb begin
        case (csr_req.addr)
            csr_tselect: csr_rdata = 32'(tselect);
            csr_tdata1:  csr_rdata = sel_ctrl;
            csr_tdata2:  csr_rdata = tdata2_q[tselect];
            default:     csr_rdata = '0;
        endcase
    end

    always_comb begin
        for (int i = 0; i < `TRIG_NUM; i++) begin
            trig_cfg[i].ctrl   = ctrl_q[i];
            trig_cfg[i].tdata2 = tdata2_q[i];
        end
    end

endmodule

`default_nettype wire

// ==== src/trig_pkg.sv ====
// Trigger module types
`default_nettype none

`include "trig_cfg.svh"

package trig_pkg;

    typedef logic [`TRIG_VALEN-1:0] trig_addr_t;

    typedef enum logic [1:0] {
        priv_user    = 2'b00,
        priv_machine = 2'b11
    } priv_e;

    typedef enum logic [1:0] {
        csr_tselect = 2'd0,
        csr_tdata1  = 2'd1,
        csr_tdata2  = 2'd2
    } csr_addr_e;

    typedef struct packed {
        logic        we;
        csr_addr_e   addr;
        logic [31:0] wdata;
    } csr_req_t;

    typedef enum logic [3:0] {
        type_none       = 4'd0,
        type_addr_match = 4'd2
    } trig_type_e;

    typedef enum logic [3:0] {
        match_eq   = 4'd0,
        match_mask = 4'd1,
        match_ge   = 4'd2,
        match_lt   = 4'd3
    } trig_match_e;

    typedef enum logic [5:0] {
        action_brk  = 6'd0,
        action_halt = 6'd1
    } trig_action_e;

    // tdata1 layout, bit 31 down to bit 0.
    typedef struct packed {
        trig_type_e   ttype;   // [31:28]
        logic         dmode;   // [27] debug-mode only.
        logic [10:0]  zero;    // [26:16] reads as zero.
        trig_action_e action;  // [15:10]
        logic         chain;   // [9]
        trig_match_e  match;   // [8:5]
        logic         m;       // [4]
        logic         u;       // [3]
        logic         execute; // [2]
        logic         store;   // [1]
        logic         load;    // [0]
    } trig_ctrl_t;

    typedef struct packed {
        trig_ctrl_t  ctrl;
        logic [31:0] tdata2;
    } trig_cfg_t;

    typedef struct packed {
        logic       load;
        logic       store;
        trig_addr_t addr;
    } ls_req_t;

    typedef struct packed {
        logic brk;
        logic halt;
    } trig_result_t;

endpackage

`default_nettype wire

// ==== include/trig_cfg.svh ====
// Trigger module configuration

`ifndef TRIG_CFG_SVH
`define TRIG_CFG_SVH

// number of address-match triggers, 2, 4 or 8.
`define TRIG_NUM 4

// tselect index width, log2 of the trigger count.
`define TRIG_SEL_W 2

// virtual address width seen by the comparators.
`define TRIG_VALEN 32

`endif
